/* src.f */
+incdir+source
source/periph_pkg.sv
source/apb_interconnect.sv
source/riscv_timer.sv
source/uart_tx.sv
source/periph_subsys.sv
tb/tb_clk_gen.sv
tb/tb_periph_subsys.sv

/* Bender.yml */
package:
  name: periph_subsys

sources:
  - include_dirs:
      - source
    files:
      - source/periph_pkg.sv
      - source/apb_interconnect.sv
      - source/riscv_timer.sv
      - source/uart_tx.sv
      - source/periph_subsys.sv
  - target: test
    include_dirs:
      - source
    files:
      - tb/tb_clk_gen.sv
      - tb/tb_periph_subsys.sv

/* tb/tb_periph_subsys.sv */
`timescale 1ns/1ps
`default_nettype none

`include "periph_cfg.svh"

module tb_periph_subsys import periph_pkg::*; ();

	localparam int CLK_PERIOD = 40;
	localparam int SEED       = 85243;
	localparam int N_TICKS    = 40;
	localparam int HALT_WAIT  = 300;
	localparam int DIV_MAX    = 20;
	localparam int START_WAIT = 50;
	// Three cycles per APB access, fewer than 100 accesses in all
	localparam int BUS_CYCLES = 100 * 3;
	localparam int RUN_CYCLES = 10 + BUS_CYCLES + N_TICKS * `PERIPH_CLK_MHZ + HALT_WAIT
		+ 2 * (START_WAIT + 10 * DIV_MAX) + 12 * DIV_MAX + 2000;

	localparam logic [15:0] A_CTRL      = `PERIPH_TIMER_BASE + `TMR_CTRL;
	localparam logic [15:0] A_MTIME     = `PERIPH_TIMER_BASE + `TMR_MTIME;
	localparam logic [15:0] A_MTIMEH    = `PERIPH_TIMER_BASE + `TMR_MTIMEH;
	localparam logic [15:0] A_MTIMECMP  = `PERIPH_TIMER_BASE + `TMR_MTIMECMP;
	localparam logic [15:0] A_MTIMECMPH = `PERIPH_TIMER_BASE + `TMR_MTIMECMPH;
	localparam logic [15:0] A_CSR       = `PERIPH_UART_BASE + `UART_CSR;
	localparam logic [15:0] A_DIV       = `PERIPH_UART_BASE + `UART_DIV;
	localparam logic [15:0] A_TXDATA    = `PERIPH_UART_BASE + `UART_TXDATA;

	logic        clk;
	logic        rst_n;
	apb_req_t    apb;
	logic [31:0] prdata;
	logic        pslverr;
	logic        dbg_halt;
	logic        tx;
	logic        timer_irq;

	tb_clk_gen #(
		.PERIOD     (CLK_PERIOD),
		.RST_CYCLES (10)
	) clk_gen_u (
		.clk   (clk),
		.rst_n (rst_n)
	);

	periph_subsys dut_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.apb       (apb),
		.prdata    (prdata),
		.pslverr   (pslverr),
		.dbg_halt  (dbg_halt),
		.tx        (tx),
		.timer_irq (timer_irq)
	);

	// ---------------------------------------------------------
	// Failure reporting

	task automatic value_error(input string msg);
		$display("[ERROR] %0t: %s", $time, msg);
		$display("TEST FAIL");
		$fatal(1);
	endtask

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TEST FAIL");
		$fatal(1);
	endtask

	task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else value_error($sformatf("%s: got 0x%08h, expected 0x%08h", what, got, exp));
	endtask

	// ---------------------------------------------------------
	// APB driver, setup then access phase, sampled before the closing edge

	task automatic apb_access(input logic write, input logic [15:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		@(negedge clk);
		apb.psel    = 1'b1;
		apb.penable = 1'b0;
		apb.pwrite  = write;
		apb.paddr   = addr;
		apb.pwdata  = wdata;
		@(negedge clk);
		apb.penable = 1'b1;
		#1;
		rdata = prdata;
		err   = pslverr;
		@(negedge clk);
		apb = '0;
	endtask

	task automatic apb_write(input logic [15:0] addr, input logic [31:0] data);
		logic [31:0] rd;
		logic        err;
		apb_access(1'b1, addr, data, rd, err);
		assert (err === 1'b0) else value_error($sformatf("pslverr on write to 0x%04h", addr));
	endtask

	task automatic apb_read(input logic [15:0] addr, output logic [31:0] data);
		logic err;
		apb_access(1'b0, addr, '0, data, err);
		assert (err === 1'b0) else value_error($sformatf("pslverr on read of 0x%04h", addr));
	endtask

	task automatic read_check(input logic [15:0] addr, input logic [31:0] exp);
		logic [31:0] rd;
		apb_read(addr, rd);
		check_eq($sformatf("read 0x%04h", addr), rd, exp);
	endtask

	task automatic expect_error(input string what, input logic [31:0] rd, input logic err,
			input logic is_read);
		assert (err === 1'b1) else value_error($sformatf("%s: no pslverr", what));
		if (is_read) begin
			check_eq(what, rd, 32'h0);
		end
	endtask

	task automatic read_mtime(output logic [63:0] value);
		logic [31:0] lo;
		logic [31:0] hi;
		apb_read(A_MTIME, lo);
		apb_read(A_MTIMEH, hi);
		value = {hi, lo};
	endtask

	// ---------------------------------------------------------
	// UART line monitor, samples each bit near its centre

	task automatic uart_capture(input int div, output logic [7:0] data);
		int wait_cycles;
		int i;
		wait_cycles = 0;
		while (tx !== 1'b0) begin
			@(negedge clk);
			wait_cycles++;
			if (wait_cycles > START_WAIT) begin
				abort_run("No UART start bit seen on tx");
			end
		end
		repeat (div / 2) @(negedge clk);
		assert (tx === 1'b0) else value_error("UART start bit not low at its centre");
		for (i = 0; i < 8; i++) begin
			repeat (div) @(negedge clk);
			data[i] = tx;
		end
		repeat (div) @(negedge clk);
		assert (tx === 1'b1) else value_error("UART stop bit not high");
	endtask

	task automatic wait_uart_idle();
		logic [31:0] csr;
		int          polls;
		polls = 0;
		apb_read(A_CSR, csr);
		while (csr[0]) begin
			polls++;
			if (polls > START_WAIT) begin
				abort_run("UART stayed busy after the end of its frame");
			end
			apb_read(A_CSR, csr);
		end
	endtask

	// ---------------------------------------------------------
	// Directed tests

	task automatic reset_values();
		logic [31:0] v;
		assert (tx === 1'b1) else value_error("tx not high after reset");
		assert (timer_irq === 1'b0) else value_error("timer_irq not low after reset");
		read_check(A_CTRL, 32'h0);
		read_check(A_MTIME, 32'h0);
		read_check(A_MTIMEH, 32'h0);
		read_check(A_MTIMECMP, 32'hffff_ffff);
		read_check(A_MTIMECMPH, 32'hffff_ffff);
		read_check(A_DIV, 32'd16);
		read_check(A_CSR, 32'h0);
		v = $urandom;
		apb_write(A_MTIME, v);
		read_check(A_MTIME, v);
		v = $urandom;
		apb_write(A_MTIMEH, v);
		read_check(A_MTIMEH, v);
		v = $urandom;
		apb_write(A_MTIMECMP, v);
		read_check(A_MTIMECMP, v);
		// Keep DIV within its 16-bit field and above the minimum
		v = 32'd2 + ($urandom % 32'hfffe);
		apb_write(A_DIV, v);
		read_check(A_DIV, v);
	endtask

	task automatic bus_errors();
		logic [31:0] rd;
		logic        err;
		logic [31:0] mt;
		logic [31:0] dv;
		apb_read(A_MTIME, mt);
		apb_read(A_DIV, dv);
		apb_access(1'b0, 16'h8000 | A_MTIME, '0, rd, err);
		expect_error("read with bit 15 set", rd, err, 1'b1);
		apb_access(1'b1, 16'h8000 | A_MTIME, ~mt, rd, err);
		expect_error("write with bit 15 set", rd, err, 1'b0);
		apb_access(1'b1, 16'h8000 | A_DIV, ~dv, rd, err);
		expect_error("UART write with bit 15 set", rd, err, 1'b0);
		apb_access(1'b0, 16'h0004, '0, rd, err);
		expect_error("read of undefined timer offset", rd, err, 1'b1);
		apb_access(1'b1, 16'h0018, ~mt, rd, err);
		expect_error("write to undefined timer offset", rd, err, 1'b0);
		apb_access(1'b0, 16'h400c, '0, rd, err);
		expect_error("read of undefined UART offset", rd, err, 1'b1);
		apb_access(1'b1, 16'h4010, ~dv, rd, err);
		expect_error("write to undefined UART offset", rd, err, 1'b0);
		apb_access(1'b1, A_CSR, 32'h1, rd, err);
		expect_error("write to UART CSR", rd, err, 1'b0);
		read_check(A_MTIME, mt);
		read_check(A_DIV, dv);
		read_check(A_CSR, 32'h0);
	endtask

	task automatic timer_count();
		logic [63:0] start;
		logic [63:0] now;
		logic [63:0] delta;
		logic [31:0] first;
		logic [31:0] second;
		apb_write(A_CTRL, 32'h0);
		start = {$urandom & 32'h7fff_ffff, $urandom};
		apb_write(A_MTIME, start[31:0]);
		apb_write(A_MTIMEH, start[63:32]);
		apb_write(A_CTRL, 32'h1);
		repeat (N_TICKS * `PERIPH_CLK_MHZ) @(negedge clk);
		apb_write(A_CTRL, 32'h0);
		read_mtime(now);
		delta = now - start;
		// The enable window spans a few bus cycles beyond N ticks
		assert (delta >= 64'(N_TICKS) && delta <= 64'(N_TICKS + 1))
		else value_error($sformatf("mtime advanced by %0d, expected %0d", delta, N_TICKS));
		apb_write(A_CTRL, 32'h1);
		dbg_halt = 1'b1;
		apb_read(A_MTIME, first);
		repeat (HALT_WAIT) @(negedge clk);
		apb_read(A_MTIME, second);
		check_eq("mtime during debug halt", second, first);
		dbg_halt = 1'b0;
		apb_write(A_CTRL, 32'h0);
	endtask

	task automatic irq_compare();
		logic [63:0] mt;
		mt = {$urandom & 32'h7fff_ffff, $urandom};
		apb_write(A_MTIME, mt[31:0]);
		apb_write(A_MTIMEH, mt[63:32]);
		apb_write(A_MTIMECMPH, 32'hffff_ffff);
		apb_write(A_MTIMECMP, mt[31:0]);
		repeat (2) @(negedge clk);
		assert (timer_irq === 1'b0) else value_error("timer_irq high with mtimecmp above mtime");
		// Compare value now equals mtime
		apb_write(A_MTIMECMPH, mt[63:32]);
		repeat (2) @(negedge clk);
		assert (timer_irq === 1'b1) else value_error("timer_irq low with mtimecmp at mtime");
		apb_write(A_MTIMECMPH, mt[63:32] + 32'h1000);
		repeat (2) @(negedge clk);
		assert (timer_irq === 1'b0) else value_error("timer_irq not cleared by a far mtimecmp");
	endtask

	task automatic uart_frame();
		int         div;
		logic [7:0] sent;
		logic [7:0] seen;
		div  = 4 + ($urandom % 17);
		sent = 8'($urandom);
		apb_write(A_DIV, div);
		fork
			uart_capture(div, seen);
			begin
				apb_write(A_TXDATA, {24'h0, sent});
				read_check(A_CSR, 32'h1);
			end
		join
		check_eq("UART frame data", {24'h0, seen}, {24'h0, sent});
		wait_uart_idle();
	endtask

	task automatic busy_write();
		int         div;
		logic [7:0] first;
		logic [7:0] seen;
		div   = 4 + ($urandom % 17);
		first = 8'($urandom);
		apb_write(A_DIV, div);
		fork
			uart_capture(div, seen);
			begin
				apb_write(A_TXDATA, {24'h0, first});
				read_check(A_CSR, 32'h1);
				apb_write(A_TXDATA, {24'h0, first ^ 8'hff});
			end
		join
		check_eq("UART frame after write while busy", {24'h0, seen}, {24'h0, first});
		repeat (12 * div) begin
			@(negedge clk);
			assert (tx === 1'b1) else value_error("tx left idle after a write while busy");
		end
	endtask

	// ---------------------------------------------------------
	// Main sequence and watchdog

	initial begin
		int seed_val;
		apb         = '0;
		dbg_halt    = 1'b0;
		seed_val    = $urandom(SEED);
		wait (rst_n === 1'b1);
		@(negedge clk);
		reset_values();
		bus_errors();
		timer_count();
		irq_compare();
		uart_frame();
		busy_write();
		$display("TEST PASS");
		$finish;
	end

	initial begin
		#(RUN_CYCLES * CLK_PERIOD);
		abort_run("Watchdog expired before the tests finished");
	end

endmodule

`default_nettype wire

/* tb/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
	parameter int PERIOD     = 40,
	parameter int RST_CYCLES = 10
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// Reset released on a falling edge, away from the active edge
	initial begin
		rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire

/* source/periph_subsys.sv */
`timescale 1ns/1ps
`default_nettype none

`include "periph_cfg.svh"

module periph_subsys import periph_pkg::*; (
	input  logic                       clk,
	input  logic                       rst_n,
	input  apb_req_t                   apb,
	output logic [`PERIPH_DATA_W-1:0]  prdata,
	output logic                       pslverr,
	input  logic                       dbg_halt,
	output logic                       tx,
	output logic                       timer_irq
);

	reg_access_t tmr_acc;
	reg_access_t uart_acc;
	periph_rsp_t tmr_rsp;
	periph_rsp_t uart_rsp;

	// ---------------------------------------------------------
	// Bus decode and response select

	apb_interconnect interconnect_u (
		.clk      (clk),
		.rst_n    (rst_n),
		.apb      (apb),
		.prdata   (prdata),
		.pslverr  (pslverr),
		.tmr_acc  (tmr_acc),
		.uart_acc (uart_acc),
		.tmr_rsp  (tmr_rsp),
		.uart_rsp (uart_rsp)
	);

	// ---------------------------------------------------------
	// Peripherals

	riscv_timer timer_u (
		.clk       (clk),
		.rst_n     (rst_n),
		.acc       (tmr_acc),
		.rsp       (tmr_rsp),
		.dbg_halt  (dbg_halt),
		.timer_irq (timer_irq)
	);

	uart_tx uart_u (
		.clk   (clk),
		.rst_n (rst_n),
		.acc   (uart_acc),
		.rsp   (uart_rsp),
		.tx    (tx)
	);

endmodule

`default_nettype wire

/* source/uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

`include "periph_cfg.svh"

module uart_tx import periph_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  reg_access_t acc,
	output periph_rsp_t rsp,
	output logic        tx
);

	localparam int DW = `PERIPH_UART_DIV_W;

	uart_state_e   state;
	logic [DW-1:0] div;
	logic [DW-1:0] div_ctr;
	logic [2:0]    bit_ctr;
	logic [7:0]    shift;
	logic          busy;
	logic          bit_end;
	logic          wr_div;
	logic          wr_txdata;

	assign busy      = (state != IDLE);
	assign bit_end   = (div_ctr == '0);
	assign wr_div    = acc.wr_stb & (acc.id == REG_UART_DIV);
	assign wr_txdata = acc.wr_stb & (acc.id == REG_UART_TXDATA);

	// Divider register, clamped at the low end
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			div <= DW'(`PERIPH_UART_DIV_RST);
		end else if (wr_div) begin
			if (acc.wdata[DW-1:0] < DW'(`PERIPH_UART_DIV_MIN)) begin
				div <= DW'(`PERIPH_UART_DIV_MIN);
			end else begin
				div <= acc.wdata[DW-1:0];
			end
		end
	end

	// ---------------------------------------------------------
	// Transmit FSM, one start bit, 8 data bits LSB first, one stop bit

	always_ff @(posedge clk) begin
		if (wr_txdata && !busy) begin
			shift <= acc.wdata[7:0];
		end else if (bit_end && (state == START || state == DATA)) begin
			shift <= {1'b0, shift[7:1]};
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= IDLE;
			div_ctr <= '0;
			bit_ctr <= '0;
			tx      <= 1'b1;
		end else begin
			if (busy) begin
				div_ctr <= bit_end ? div - 1'b1 : div_ctr - 1'b1;
			end
			case (state)
				IDLE: begin
					// Writes during a frame are dropped
					if (wr_txdata) begin
						state   <= START;
						div_ctr <= div - 1'b1;
						tx      <= 1'b0;
					end
				end
				START: begin
					if (bit_end) begin
						state   <= DATA;
						bit_ctr <= '0;
						tx      <= shift[0];
					end
				end
				DATA: begin
					if (bit_end) begin
						if (bit_ctr == 3'd7) begin
							state <= STOP;
							tx    <= 1'b1;
						end else begin
							bit_ctr <= bit_ctr + 1'b1;
							tx      <= shift[0];
						end
					end
				end
				STOP: begin
					if (bit_end) begin
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// CSR is read-only
	always_comb begin
		rsp.rdata = '0;
		rsp.err   = acc.wr_stb & (acc.id == REG_UART_CSR);
		if (acc.rd_stb) begin
			case (acc.id)
				REG_UART_CSR: rsp.rdata = `PERIPH_DATA_W'(busy);
				REG_UART_DIV: rsp.rdata = `PERIPH_DATA_W'(div);
				default:      rsp.rdata = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

/* source/riscv_timer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "periph_cfg.svh"

module riscv_timer import periph_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  reg_access_t acc,
	output periph_rsp_t rsp,
	input  logic        dbg_halt,
	output logic        timer_irq
);

	localparam int TICK_W = $clog2(`PERIPH_CLK_MHZ + 1);

	logic [TICK_W-1:0] tick_ctr;
	logic              tick;
	logic              count_en;
	logic              ctrl_en;
	logic [63:0]       mtime;
	logic [63:0]       mtimecmp;

	logic wr_ctrl;
	logic wr_mtime;
	logic wr_mtimeh;
	logic wr_mtimecmp;
	logic wr_mtimecmph;

	assign wr_ctrl      = acc.wr_stb & (acc.id == REG_TMR_CTRL);
	assign wr_mtime     = acc.wr_stb & (acc.id == REG_TMR_MTIME);
	assign wr_mtimeh    = acc.wr_stb & (acc.id == REG_TMR_MTIMEH);
	assign wr_mtimecmp  = acc.wr_stb & (acc.id == REG_TMR_MTIMECMP);
	assign wr_mtimecmph = acc.wr_stb & (acc.id == REG_TMR_MTIMECMPH);

	// ---------------------------------------------------------
	// Microsecond prescaler

	assign tick = (tick_ctr == '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tick_ctr <= TICK_W'(`PERIPH_CLK_MHZ - 1);
		end else if (tick) begin
			tick_ctr <= TICK_W'(`PERIPH_CLK_MHZ - 1);
		end else begin
			tick_ctr <= tick_ctr - 1'b1;
		end
	end

	// Frozen while the hart is halted in debug
	assign count_en = tick & ctrl_en & ~dbg_halt;

	// ---------------------------------------------------------
	// Registers

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ctrl_en <= 1'b0;
		end else if (wr_ctrl) begin
			ctrl_en <= acc.wdata[0];
		end
	end

	// A software write beats a tick in the same cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mtime <= '0;
		end else begin
			if (count_en) begin
				mtime <= mtime + 64'd1;
			end
			if (wr_mtime) begin
				mtime[31:0] <= acc.wdata;
			end
			if (wr_mtimeh) begin
				mtime[63:32] <= acc.wdata;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mtimecmp <= '1;
		end else begin
			if (wr_mtimecmp) begin
				mtimecmp[31:0] <= acc.wdata;
			end
			if (wr_mtimecmph) begin
				mtimecmp[63:32] <= acc.wdata;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			timer_irq <= 1'b0;
		end else begin
			timer_irq <= (mtime >= mtimecmp);
		end
	end

	// ---------------------------------------------------------
	// Read data

	always_comb begin
		rsp.rdata = '0;
		rsp.err   = 1'b0;
		if (acc.rd_stb) begin
			case (acc.id)
				REG_TMR_CTRL:      rsp.rdata = `PERIPH_DATA_W'(ctrl_en);
				REG_TMR_MTIME:     rsp.rdata = mtime[31:0];
				REG_TMR_MTIMEH:    rsp.rdata = mtime[63:32];
				REG_TMR_MTIMECMP:  rsp.rdata = mtimecmp[31:0];
				REG_TMR_MTIMECMPH: rsp.rdata = mtimecmp[63:32];
				default:           rsp.rdata = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

/* source/apb_interconnect.sv */
`timescale 1ns/1ps
`default_nettype none

`include "periph_cfg.svh"

module apb_interconnect import periph_pkg::*; (
	input  logic                       clk,
	input  logic                       rst_n,
	input  apb_req_t                   apb,
	output logic [`PERIPH_DATA_W-1:0]  prdata,
	output logic                       pslverr,
	output reg_access_t                tmr_acc,
	output reg_access_t                uart_acc,
	input  periph_rsp_t                tmr_rsp,
	input  periph_rsp_t                uart_rsp
);

	logic [`PERIPH_OFFS_W-1:0] offs;
	logic                      setup;
	logic                      access;
	logic                      hit;
	periph_sel_e               dec_sel;
	reg_id_e                   dec_reg;
	periph_sel_e               sel_q;
	reg_id_e                   reg_q;

	assign offs   = apb.paddr[`PERIPH_OFFS_W-1:0];
	assign setup  = apb.psel & ~apb.penable;
	assign access = apb.psel & apb.penable;
	assign hit    = access & (sel_q != SEL_NONE) & (reg_q != REG_INVALID);

	// ---------------------------------------------------------
	// Request path, address decode in the setup phase

	always_comb begin
		dec_sel = SEL_NONE;
		dec_reg = REG_INVALID;
		if (!apb.paddr[`PERIPH_UNMAPPED_BIT]) begin
			if ((apb.paddr & `PERIPH_WIN_MASK) == `PERIPH_UART_BASE) begin
				dec_sel = SEL_UART;
				case (offs)
					`UART_CSR:    dec_reg = REG_UART_CSR;
					`UART_DIV:    dec_reg = REG_UART_DIV;
					`UART_TXDATA: dec_reg = REG_UART_TXDATA;
					default:      dec_reg = REG_INVALID;
				endcase
			end else if ((apb.paddr & `PERIPH_WIN_MASK) == `PERIPH_TIMER_BASE) begin
				dec_sel = SEL_TIMER;
				case (offs)
					`TMR_CTRL:      dec_reg = REG_TMR_CTRL;
					`TMR_MTIME:     dec_reg = REG_TMR_MTIME;
					`TMR_MTIMEH:    dec_reg = REG_TMR_MTIMEH;
					`TMR_MTIMECMP:  dec_reg = REG_TMR_MTIMECMP;
					`TMR_MTIMECMPH: dec_reg = REG_TMR_MTIMECMPH;
					default:        dec_reg = REG_INVALID;
				endcase
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sel_q <= SEL_NONE;
			reg_q <= REG_INVALID;
		end else if (setup) begin
			sel_q <= dec_sel;
			reg_q <= dec_reg;
		end
	end

	// Strobes only in the access phase, never for a bad address
	always_comb begin
		tmr_acc.wr_stb  = hit & apb.pwrite & (sel_q == SEL_TIMER);
		tmr_acc.rd_stb  = hit & ~apb.pwrite & (sel_q == SEL_TIMER);
		tmr_acc.id      = reg_q;
		tmr_acc.wdata   = apb.pwdata;
		uart_acc.wr_stb = hit & apb.pwrite & (sel_q == SEL_UART);
		uart_acc.rd_stb = hit & ~apb.pwrite & (sel_q == SEL_UART);
		uart_acc.id     = reg_q;
		uart_acc.wdata  = apb.pwdata;
	end

	// ---------------------------------------------------------
	// Response path

	always_comb begin
		prdata  = '0;
		pslverr = 1'b0;
		if (access) begin
			if (!hit) begin
				pslverr = 1'b1;
			end else if (sel_q == SEL_TIMER) begin
				prdata  = tmr_rsp.rdata;
				pslverr = tmr_rsp.err;
			end else begin
				prdata  = uart_rsp.rdata;
				pslverr = uart_rsp.err;
			end
		end
	end

endmodule

`default_nettype wire

/* source/periph_pkg.sv */
`default_nettype none

`include "periph_cfg.svh"

package periph_pkg;

	// Request half of the external APB port
	typedef struct packed {
		logic                        psel;
		logic                        penable;
		logic                        pwrite;
		logic [`PERIPH_PADDR_W-1:0]  paddr;
		logic [`PERIPH_DATA_W-1:0]   pwdata;
	} apb_req_t;

	typedef enum logic [1:0] {
		SEL_TIMER,
		SEL_UART,
		SEL_NONE
	} periph_sel_e;

	typedef enum logic [3:0] {
		REG_TMR_CTRL,
		REG_TMR_MTIME,
		REG_TMR_MTIMEH,
		REG_TMR_MTIMECMP,
		REG_TMR_MTIMECMPH,
		REG_UART_CSR,
		REG_UART_DIV,
		REG_UART_TXDATA,
		REG_INVALID
	} reg_id_e;

	// One-cycle register access, as seen by a peripheral
	typedef struct packed {
		logic                        wr_stb;
		logic                        rd_stb;
		reg_id_e                     id;
		logic [`PERIPH_DATA_W-1:0]   wdata;
	} reg_access_t;

	typedef struct packed {
		logic [`PERIPH_DATA_W-1:0]   rdata;
		logic                        err;
	} periph_rsp_t;

	typedef enum logic [1:0] {
		IDLE,
		START,
		DATA,
		STOP
	} uart_state_e;

endpackage

`default_nettype wire

/* source/periph_cfg.svh */
`ifndef PERIPH_CFG_SVH
`define PERIPH_CFG_SVH

// Clock rate, sets the microsecond tick of the timer
`define PERIPH_CLK_MHZ      12

// APB widths and address map
`define PERIPH_PADDR_W      16
`define PERIPH_DATA_W       32
`define PERIPH_OFFS_W       14
`define PERIPH_UNMAPPED_BIT 15
`define PERIPH_WIN_MASK     16'h4000
`define PERIPH_UART_BASE    16'h4000
`define PERIPH_TIMER_BASE   16'h0000

// Timer register offsets
`define TMR_CTRL            14'h0000
`define TMR_MTIME           14'h0008
`define TMR_MTIMEH          14'h000c
`define TMR_MTIMECMP        14'h0010
`define TMR_MTIMECMPH       14'h0014

// UART register offsets and divider limits
`define UART_CSR            14'h0000
`define UART_DIV            14'h0004
`define UART_TXDATA         14'h0008
`define PERIPH_UART_DIV_W   16
`define PERIPH_UART_DIV_RST 16
`define PERIPH_UART_DIV_MIN 2

`endif
